// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Sequencing states of the multicycle core
  typedef enum logic [1:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    HALTED
  } cpu_state_e;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  // Branch offset bits are scattered, bit 0 is implicit
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  // Upper 20 bits in this order also give the LUI immediate
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // One instruction word, viewed in any format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    j_type_t j;
  } instr_u;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } bus_req_t;

  // Retire record, all zero when not valid
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
  } trace_t;

  localparam logic [31:0] HALT_WORD = 32'h0000_00FF;

endpackage

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::instr_u i_instr,
  input  logic            i_exec_en,
  input  logic [31:0]     i_pc,
  input  logic [31:0]     i_rs1_data,
  input  logic [31:0]     i_rs2_data,
  output logic            o_we,
  output logic [31:0]     o_result,
  output logic            o_pc_load,
  output logic [31:0]     o_next_pc,
  output cpu_pkg::trace_t o_trace
);

  cpu_pkg::opcode_e opcode;
  cpu_pkg::alu_op_e alu_op;
  logic [31:0]      imm_i;
  logic [31:0]      imm_b;
  logic [31:0]      imm_j;
  logic [31:0]      imm_u;
  logic [31:0]      operand_b;
  logic [31:0]      alu_out;
  logic [31:0]      pc_plus4;
  logic             writes_rd;
  logic             is_mem;
  logic             taken;

  assign opcode   = cpu_pkg::opcode_e'(i_instr.r.opcode);
  assign pc_plus4 = i_pc + 32'd4;

  // Immediates per format
  assign imm_i = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
  assign imm_b = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                  i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
  assign imm_j = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                  i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
  assign imm_u = {i_instr.j.imm20, i_instr.j.imm10_1, i_instr.j.imm11,
                  i_instr.j.imm19_12, 12'h000};

  always_comb begin
    case (i_instr.r.funct3)
      3'b000: begin
        // SUB only exists in the register form
        if ((opcode == cpu_pkg::OP) && i_instr.r.funct7[5]) begin
          alu_op = cpu_pkg::ALU_SUB;
        end else begin
          alu_op = cpu_pkg::ALU_ADD;
        end
      end
      3'b010:  alu_op = cpu_pkg::ALU_SLT;
      3'b100:  alu_op = cpu_pkg::ALU_XOR;
      3'b110:  alu_op = cpu_pkg::ALU_OR;
      3'b111:  alu_op = cpu_pkg::ALU_AND;
      default: alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

  assign operand_b = (opcode == cpu_pkg::OP) ? i_rs2_data : imm_i;

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_SUB: alu_out = i_rs1_data - operand_b;
      cpu_pkg::ALU_AND: alu_out = i_rs1_data & operand_b;
      cpu_pkg::ALU_OR:  alu_out = i_rs1_data | operand_b;
      cpu_pkg::ALU_XOR: alu_out = i_rs1_data ^ operand_b;
      cpu_pkg::ALU_SLT: alu_out = {31'h0, $signed(i_rs1_data) < $signed(operand_b)};
      default:          alu_out = i_rs1_data + operand_b;
    endcase
  end

  always_comb begin
    case (opcode)
      cpu_pkg::OP,
      cpu_pkg::OP_IMM: o_result = alu_out;
      cpu_pkg::LUI:    o_result = imm_u;
      cpu_pkg::JAL:    o_result = pc_plus4;
      default:         o_result = 32'h0;
    endcase
  end

  assign writes_rd = (opcode == cpu_pkg::OP) || (opcode == cpu_pkg::OP_IMM) ||
                     (opcode == cpu_pkg::LUI) || (opcode == cpu_pkg::JAL);
  assign is_mem    = (opcode == cpu_pkg::LOAD) || (opcode == cpu_pkg::STORE);

  // funct3[0] selects BNE over BEQ
  assign taken = i_instr.b.funct3[0] ? (i_rs1_data != i_rs2_data)
                                     : (i_rs1_data == i_rs2_data);

  always_comb begin
    if (opcode == cpu_pkg::JAL) begin
      o_next_pc = i_pc + imm_j;
    end else if ((opcode == cpu_pkg::BRANCH) && taken) begin
      o_next_pc = i_pc + imm_b;
    end else begin
      o_next_pc = pc_plus4;
    end
  end

  // Loads and stores also step the PC here, they retire later from load_store
  assign o_pc_load = i_exec_en;
  assign o_we      = i_exec_en && writes_rd;

  always_comb begin
    o_trace = '0;
    if (i_exec_en && !is_mem) begin
      o_trace.valid = 1'b1;
      o_trace.pc    = i_pc;
      if (writes_rd) begin
        o_trace.rd    = i_instr.r.rd;
        o_trace.value = (i_instr.r.rd != 5'd0) ? o_result : 32'h0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_fetch_req,
  input  cpu_pkg::bus_req_t i_fetch_cmd,
  input  logic              i_lsu_req,
  input  cpu_pkg::bus_req_t i_lsu_cmd,
  input  logic              i_bus_dv,
  input  logic [31:0]       i_bus_rdata,
  output logic              o_bus_req,
  output cpu_pkg::bus_req_t o_bus_cmd,
  output logic              o_fetch_dv,
  output logic              o_lsu_dv,
  output logic [31:0]       o_resp_data
);

  logic busy;
  logic owner_lsu;

  // Fixed priority, load/store wins
  assign o_bus_req = i_fetch_req || i_lsu_req;
  assign o_bus_cmd = i_lsu_req ? i_lsu_cmd : i_fetch_cmd;

  // Owner held until the single outstanding response
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy      <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (o_bus_req) begin
      busy      <= 1'b1;
      owner_lsu <= i_lsu_req;
    end else if (i_bus_dv) begin
      busy      <= 1'b0;
    end
  end

  assign o_fetch_dv  = i_bus_dv && !owner_lsu;
  assign o_lsu_dv    = i_bus_dv && owner_lsu;
  assign o_resp_data = i_bus_rdata;

  a_one_outstanding: assert property (@(posedge i_clk) disable iff (i_rst)
    o_bus_req |-> !busy);

  a_no_stray_dv: assert property (@(posedge i_clk) disable iff (i_rst)
    i_bus_dv |-> busy);

endmodule

`default_nettype wire

// File: src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic            i_clk,
  input  logic            i_rst,
  input  cpu_pkg::instr_u i_instr,
  input  logic            i_fetch_done,
  input  logic            i_mem_done,
  output logic            o_start_fetch,
  output logic            o_exec_en,
  output logic            o_start_mem,
  output logic            o_halted
);

  cpu_pkg::cpu_state_e state;
  cpu_pkg::cpu_state_e state_d;
  cpu_pkg::opcode_e    opcode;
  logic                is_mem;
  logic                is_halt;
  logic                booted;
  logic                launch;

  assign opcode  = cpu_pkg::opcode_e'(i_instr.r.opcode);
  assign is_mem  = (opcode == cpu_pkg::LOAD) || (opcode == cpu_pkg::STORE);
  assign is_halt = (i_instr == cpu_pkg::HALT_WORD);

  always_comb begin
    state_d = state;
    case (state)
      cpu_pkg::FETCH: begin
        if (i_fetch_done) begin
          state_d = cpu_pkg::EXECUTE;
        end
      end
      cpu_pkg::EXECUTE: begin
        if (is_halt) begin
          state_d = cpu_pkg::HALTED;
        end else if (is_mem) begin
          state_d = cpu_pkg::MEMORY;
        end else begin
          state_d = cpu_pkg::FETCH;
        end
      end
      cpu_pkg::MEMORY: begin
        if (i_mem_done) begin
          state_d = cpu_pkg::FETCH;
        end
      end
      default: state_d = cpu_pkg::HALTED;
    endcase
  end

  // Fetch strobe fires in the first cycle of every FETCH visit
  assign launch = !booted ||
                  ((state == cpu_pkg::EXECUTE) && !is_halt && !is_mem) ||
                  ((state == cpu_pkg::MEMORY) && i_mem_done);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= cpu_pkg::FETCH;
      booted        <= 1'b0;
      o_start_fetch <= 1'b0;
    end else begin
      state         <= state_d;
      booted        <= 1'b1;
      o_start_fetch <= launch;
    end
  end

  // The halt word never executes or retires
  assign o_exec_en   = (state == cpu_pkg::EXECUTE) && !is_halt;
  assign o_start_mem = (state == cpu_pkg::EXECUTE) && !is_halt && is_mem;
  assign o_halted    = (state == cpu_pkg::HALTED);

  // Fetch and memory step must never compete for the bus
  a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_start_fetch && o_start_mem));

endmodule

`default_nettype wire

// File: src/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_start_fetch,
  input  logic              i_resp_dv,
  input  logic [31:0]       i_resp_data,
  input  logic              i_pc_load,
  input  logic [31:0]       i_next_pc,
  output logic              o_req,
  output cpu_pkg::bus_req_t o_req_cmd,
  output logic              o_fetch_done,
  output logic [31:0]       o_pc,
  output cpu_pkg::instr_u   o_instr
);

  logic [31:0]     pc;
  cpu_pkg::instr_u ir;

  // PC moves once per retired instruction, at the end of EXECUTE
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= RESET_PC;
    end else if (i_pc_load) begin
      pc <= i_next_pc;
    end
  end

  // IR captures the routed fetch response
  always_ff @(posedge i_clk) begin
    if (i_resp_dv) begin
      ir <= i_resp_data;
    end
  end

  // Read request at the current PC
  assign o_req     = i_start_fetch;
  assign o_req_cmd = '{addr: pc, wdata: 32'h0, we: 1'b0};

  assign o_fetch_done = i_resp_dv;
  assign o_pc         = pc;
  assign o_instr      = ir;

endmodule

`default_nettype wire

// File: src/load_store.sv
`timescale 1ns/1ps
`default_nettype none

module load_store (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cpu_pkg::instr_u   i_instr,
  input  logic              i_start_mem,
  input  logic [31:0]       i_rs1_data,
  input  logic [31:0]       i_rs2_data,
  input  logic [31:0]       i_pc,
  input  logic              i_resp_dv,
  input  logic [31:0]       i_resp_data,
  output logic              o_req,
  output cpu_pkg::bus_req_t o_req_cmd,
  output logic              o_mem_done,
  output logic              o_load_we,
  output logic [31:0]       o_load_data,
  output cpu_pkg::trace_t   o_trace
);

  logic        is_store;
  logic [31:0] imm;
  logic [31:0] mem_addr;
  logic        load_q;
  logic [4:0]  rd_q;
  logic [31:0] pc_q;

  assign is_store = (cpu_pkg::opcode_e'(i_instr.s.opcode) == cpu_pkg::STORE);
  assign imm      = is_store ? {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo}
                             : {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
  assign mem_addr = i_rs1_data + imm;

  assign o_req     = i_start_mem;
  assign o_req_cmd = '{addr: mem_addr, wdata: i_rs2_data, we: is_store};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      load_q <= 1'b0;
    end else if (i_start_mem) begin
      load_q <= !is_store;
    end
  end

  // PC has already stepped by the time the response returns
  always_ff @(posedge i_clk) begin
    if (i_start_mem) begin
      pc_q <= i_pc;
      rd_q <= i_instr.i.rd;
    end
  end

  assign o_mem_done  = i_resp_dv;
  assign o_load_we   = i_resp_dv && load_q;
  assign o_load_data = i_resp_data;

  // Stores retire with rd 0 and value 0
  always_comb begin
    o_trace = '0;
    if (i_resp_dv) begin
      o_trace.valid = 1'b1;
      o_trace.pc    = pc_q;
      if (load_q) begin
        o_trace.rd    = rd_q;
        o_trace.value = (rd_q != 5'd0) ? i_resp_data : 32'h0;
      end
    end
  end

  a_word_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_start_mem |-> (mem_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic            i_clk,
  input  logic            i_rst,
  input  cpu_pkg::instr_u i_instr,
  input  logic            i_we,
  input  logic [31:0]     i_wdata,
  output logic [31:0]     o_rs1_data,
  output logic [31:0]     o_rs2_data
);

  logic [31:0] regs [32];
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;

  assign rs1 = i_instr.r.rs1;
  assign rs2 = i_instr.r.rs2;
  assign rd  = i_instr.r.rd;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= 32'h0;
      end
    end else if (i_we && (rd != 5'd0)) begin
      regs[rd] <= i_wdata;
    end
  end

  // x0 reads as zero
  assign o_rs1_data = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
  assign o_rs2_data = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [31:0]       i_bus_rdata,
  input  logic              i_bus_dv,
  output logic              o_bus_req,
  output cpu_pkg::bus_req_t o_bus_cmd,
  output cpu_pkg::trace_t   o_trace,
  output logic              o_halted
);

  // Sequencing strobes
  logic w_start_fetch;
  logic w_exec_en;
  logic w_start_mem;
  logic w_fetch_done;
  logic w_mem_done;

  // Fetch side
  cpu_pkg::instr_u   w_instr;
  logic [31:0]       w_pc;
  logic              w_fetch_req;
  cpu_pkg::bus_req_t w_fetch_cmd;
  logic              w_fetch_dv;

  // Load/store side
  logic              w_lsu_req;
  cpu_pkg::bus_req_t w_lsu_cmd;
  logic              w_lsu_dv;
  logic              w_load_we;
  logic [31:0]       w_load_data;
  cpu_pkg::trace_t   w_lsu_trace;
  logic [31:0]       w_resp_data;

  // Execute side
  logic              w_alu_we;
  logic [31:0]       w_alu_result;
  logic              w_pc_load;
  logic [31:0]       w_next_pc;
  cpu_pkg::trace_t   w_alu_trace;

  // Register file
  logic              w_rf_we;
  logic [31:0]       w_rf_wdata;
  logic [31:0]       w_rs1_data;
  logic [31:0]       w_rs2_data;

  // Writeback comes from the ALU in EXECUTE or from a load in MEMORY
  assign w_rf_we    = w_alu_we | w_load_we;
  assign w_rf_wdata = w_load_we ? w_load_data : w_alu_result;

  // At most one retire source is valid per cycle
  assign o_trace = w_alu_trace | w_lsu_trace;

  control_unit m_control (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_instr      (w_instr),
    .i_fetch_done (w_fetch_done),
    .i_mem_done   (w_mem_done),
    .o_start_fetch(w_start_fetch),
    .o_exec_en    (w_exec_en),
    .o_start_mem  (w_start_mem),
    .o_halted     (o_halted)
  );

  instruction_fetch #(
    .RESET_PC(RESET_PC)
  ) m_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start_fetch(w_start_fetch),
    .i_resp_dv    (w_fetch_dv),
    .i_resp_data  (w_resp_data),
    .i_pc_load    (w_pc_load),
    .i_next_pc    (w_next_pc),
    .o_req        (w_fetch_req),
    .o_req_cmd    (w_fetch_cmd),
    .o_fetch_done (w_fetch_done),
    .o_pc         (w_pc),
    .o_instr      (w_instr)
  );

  register_file m_regfile (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_instr   (w_instr),
    .i_we      (w_rf_we),
    .i_wdata   (w_rf_wdata),
    .o_rs1_data(w_rs1_data),
    .o_rs2_data(w_rs2_data)
  );

  alu m_alu (
    .i_instr   (w_instr),
    .i_exec_en (w_exec_en),
    .i_pc      (w_pc),
    .i_rs1_data(w_rs1_data),
    .i_rs2_data(w_rs2_data),
    .o_we      (w_alu_we),
    .o_result  (w_alu_result),
    .o_pc_load (w_pc_load),
    .o_next_pc (w_next_pc),
    .o_trace   (w_alu_trace)
  );

  load_store m_load_store (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_instr    (w_instr),
    .i_start_mem(w_start_mem),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .i_pc       (w_pc),
    .i_resp_dv  (w_lsu_dv),
    .i_resp_data(w_resp_data),
    .o_req      (w_lsu_req),
    .o_req_cmd  (w_lsu_cmd),
    .o_mem_done (w_mem_done),
    .o_load_we  (w_load_we),
    .o_load_data(w_load_data),
    .o_trace    (w_lsu_trace)
  );

  bus_arbiter m_arbiter (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_fetch_req(w_fetch_req),
    .i_fetch_cmd(w_fetch_cmd),
    .i_lsu_req  (w_lsu_req),
    .i_lsu_cmd  (w_lsu_cmd),
    .i_bus_dv   (i_bus_dv),
    .i_bus_rdata(i_bus_rdata),
    .o_bus_req  (o_bus_req),
    .o_bus_cmd  (o_bus_cmd),
    .o_fetch_dv (w_fetch_dv),
    .o_lsu_dv   (w_lsu_dv),
    .o_resp_data(w_resp_data)
  );

endmodule

`default_nettype wire

// File: tests/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Instruction-level model of the RV32I subset, run over the whole program before reset ends

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_JAL    = 7'b1101111;

logic [31:0] ref_mem [1024];
logic [31:0] ref_regs [32];
int          ref_steps;

// Expected retire records in program order
logic [31:0] exp_pc [$];
logic [4:0]  exp_rd [$];
logic [31:0] exp_val [$];
logic [6:0]  exp_op [$];

// Expected bus writes in order
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];

function automatic logic [31:0] alu_rule(logic [2:0] f3, logic sub, logic [31:0] a,
                                         logic [31:0] b);
  case (f3)
    3'b000:  return sub ? (a - b) : (a + b);
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b110:  return a | b;
    3'b111:  return a & b;
    default: return 32'h0;
  endcase
endfunction

task automatic run_model();
  logic [31:0] pc;
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] next_pc;
  logic [31:0] addr;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [6:0]  op;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        writes;
  logic        done;
  pc        = RESET_PC;
  ref_steps = 0;
  done      = 1'b0;
  for (int k = 0; k < 32; k++) begin
    ref_regs[k] = 32'h0;
  end
  while (!done) begin
    w = ref_mem[pc[11:2]];
    if ((w == cpu_pkg::HALT_WORD) || (ref_steps >= 1000)) begin
      done = 1'b1;
    end else begin
      op      = w[6:0];
      rd      = w[11:7];
      f3      = w[14:12];
      a       = ref_regs[w[19:15]];
      b       = ref_regs[w[24:20]];
      imm_i   = {{20{w[31]}}, w[31:20]};
      imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      next_pc = pc + 32'd4;
      res     = 32'h0;
      writes  = 1'b1;
      case (op)
        OPC_OP:     res = alu_rule(f3, w[30], a, b);
        OPC_OP_IMM: res = alu_rule(f3, 1'b0, a, imm_i);
        OPC_LUI:    res = {w[31:12], 12'h000};
        OPC_LOAD: begin
          addr = a + imm_i;
          res  = ref_mem[addr[11:2]];
        end
        OPC_STORE: begin
          writes = 1'b0;
          addr   = a + imm_s;
          ref_mem[addr[11:2]] = b;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
        end
        OPC_BRANCH: begin
          writes = 1'b0;
          if (((f3 == 3'b000) && (a == b)) || ((f3 == 3'b001) && (a != b))) begin
            next_pc = pc + imm_b;
          end
        end
        OPC_JAL: begin
          res     = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        default: begin
          other_errors++;
          $display("Model found an unknown opcode %b at PC %h", op, pc);
          done = 1'b1;
        end
      endcase
      if (!done) begin
        // x0 is never written
        if (writes && (rd != 5'd0)) begin
          ref_regs[rd] = res;
        end
        exp_pc.push_back(pc);
        exp_rd.push_back(writes ? rd : 5'd0);
        exp_val.push_back((writes && (rd != 5'd0)) ? res : 32'h0);
        exp_op.push_back(op);
        pc = next_pc;
        ref_steps++;
      end
    end
  end
endtask

`endif

// File: tests/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

  localparam logic [31:0] RESET_PC       = 32'h0000_0000;
  localparam int          N_INSTR        = 150;
  localparam int          HALT_QUIET     = 50;
  // 12 cycles per instruction at worst, plus margin for reset and the halt window
  localparam int          TIMEOUT_CYCLES = N_INSTR * 12 + 700;

  logic              i_clk;
  logic              i_rst;
  logic              i_bus_dv;
  logic [31:0]       i_bus_rdata;
  logic              o_bus_req;
  cpu_pkg::bus_req_t o_bus_cmd;
  cpu_pkg::trace_t   o_trace;
  logic              o_halted;

  logic [31:0] bus_mem [1024];
  int          value_errors;
  int          other_errors;
  int          retired;
  int          cycles;
  logic        seen_first_req;

  `include "cpu_ref_model.svh"

  cpu_top #(
    .RESET_PC(RESET_PC)
  ) i_cpu_top (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_bus_rdata(i_bus_rdata),
    .i_bus_dv   (i_bus_dv),
    .o_bus_req  (o_bus_req),
    .o_bus_cmd  (o_bus_cmd),
    .o_trace    (o_trace),
    .o_halted   (o_halted)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % 32'(hi - lo + 1));
  endfunction

  // Data fill that depends on every address bit
  function automatic logic [31:0] fill_word(int idx);
    logic [31:0] a;
    a = 32'(idx) << 2;
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0000;
  endfunction

  function automatic logic [31:0] random_instr(int idx);
    int          kind;
    int          room;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] off;
    logic [2:0]  f3;
    logic [6:0]  f7;
    kind = rand_range(0, 9);
    rd   = 5'(rand_range(0, 7));
    rs1  = 5'(rand_range(0, 7));
    rs2  = 5'(rand_range(0, 7));
    imm  = 12'(rand_range(0, 4095));
    // Forward hops only and never past the halt word
    room = N_INSTR - idx;
    off  = 32'(rand_range(1, (room < 6) ? room : 6) * 4);
    f7   = 7'b0000000;
    case (kind)
      0, 1: begin
        case (rand_range(0, 5))
          0:       f3 = 3'b000;
          1: begin
            f3 = 3'b000;
            f7 = 7'b0100000;
          end
          2:       f3 = 3'b111;
          3:       f3 = 3'b110;
          4:       f3 = 3'b100;
          default: f3 = 3'b010;
        endcase
        return {f7, rs2, rs1, f3, rd, OPC_OP};
      end
      2, 3: begin
        case (rand_range(0, 3))
          0:       f3 = 3'b000;
          1:       f3 = 3'b100;
          2:       f3 = 3'b110;
          default: f3 = 3'b111;
        endcase
        return {imm, rs1, f3, rd, OPC_OP_IMM};
      end
      4: return {20'($urandom), rd, OPC_LUI};
      5, 6: begin
        // Base x0 with a word offset into the data region
        imm = 12'(32'h400 + 32'(rand_range(0, 255)) * 32'd4);
        if (kind == 5) begin
          return {imm, 5'd0, 3'b010, rd, OPC_LOAD};
        end
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
      end
      7, 8: begin
        f3 = (kind == 7) ? 3'b000 : 3'b001;
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
      end
      default: return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endcase
  endfunction

  task automatic build_program();
    for (int k = 0; k < 1024; k++) begin
      bus_mem[k] = fill_word(k);
    end
    for (int k = 0; k < N_INSTR; k++) begin
      bus_mem[k] = random_instr(k);
    end
    bus_mem[N_INSTR] = cpu_pkg::HALT_WORD;
    for (int k = 0; k < 1024; k++) begin
      ref_mem[k] = bus_mem[k];
    end
  endtask

  task automatic report_value(string name, logic [31:0] expected, logic [31:0] actual);
    value_errors++;
    $display("Error %s: expected %h, actual %h", name, expected, actual);
  endtask

  function automatic string check_name(logic [6:0] op, logic [4:0] rd);
    string name;
    case (op)
      OPC_LOAD:            name = "load";
      OPC_STORE:           name = "store";
      OPC_BRANCH, OPC_JAL: name = "control";
      default:             name = "arith";
    endcase
    if ((rd == 5'd0) && (op != OPC_STORE) && (op != OPC_BRANCH)) begin
      name = "x0";
    end
    return name;
  endfunction

  task automatic check_retire();
    logic [31:0] pc_e;
    logic [4:0]  rd_e;
    logic [31:0] val_e;
    logic [6:0]  op;
    string       name;
    retired++;
    if (exp_pc.size() == 0) begin
      other_errors++;
      $display("Retire at PC %h after the expected program had ended", o_trace.pc);
      return;
    end
    pc_e  = exp_pc.pop_front();
    rd_e  = exp_rd.pop_front();
    val_e = exp_val.pop_front();
    op    = exp_op.pop_front();
    name  = check_name(op, rd_e);
    if (o_trace.pc !== pc_e) begin
      report_value("control_pc", pc_e, o_trace.pc);
    end
    if (o_trace.rd !== rd_e) begin
      report_value({name, "_rd"}, 32'(rd_e), 32'(o_trace.rd));
    end
    if (o_trace.value !== val_e) begin
      report_value({name, "_value"}, val_e, o_trace.value);
    end
    if ((op == OPC_JAL) && (rd_e != 5'd0) && (o_trace.value !== pc_e + 32'd4)) begin
      report_value("jal_link", pc_e + 32'd4, o_trace.value);
    end
  endtask

  // Memory responder that answers after 1 to 4 cycles
  task automatic serve_request();
    cpu_pkg::bus_req_t cmd;
    int                lat;
    logic [31:0]       addr_e;
    logic [31:0]       data_e;
    cmd = o_bus_cmd;
    lat = rand_range(1, 4);
    if (!seen_first_req) begin
      seen_first_req = 1'b1;
      if (cmd.we || (cmd.addr !== RESET_PC)) begin
        other_errors++;
        $display("First bus request after reset is not a read at the reset PC");
      end
    end
    if (cmd.we) begin
      if (exp_st_addr.size() == 0) begin
        other_errors++;
        $display("Bus write to %h that the program does not make", cmd.addr);
      end else begin
        addr_e = exp_st_addr.pop_front();
        data_e = exp_st_data.pop_front();
        if (cmd.addr !== addr_e) begin
          report_value("store_addr", addr_e, cmd.addr);
        end
        if (cmd.wdata !== data_e) begin
          report_value("store_data", data_e, cmd.wdata);
        end
      end
      bus_mem[cmd.addr[11:2]] = cmd.wdata;
    end
    repeat (lat) @(posedge i_clk);
    #2;
    i_bus_rdata = cmd.we ? 32'h0 : bus_mem[cmd.addr[11:2]];
    i_bus_dv    = 1'b1;
    @(posedge i_clk);
    #2;
    i_bus_dv    = 1'b0;
    i_bus_rdata = 32'h0;
  endtask

  always begin
    @(negedge i_clk);
    if (!i_rst && (o_bus_req === 1'b1)) begin
      serve_request();
    end
  end

  // Outputs are sampled mid-cycle
  always @(negedge i_clk) begin
    if (i_rst) begin
      if ((cycles > 0) &&
          ((o_bus_req !== 1'b0) || (o_halted !== 1'b0) || (o_trace.valid !== 1'b0))) begin
        other_errors++;
        $display("Bus request, halt or trace not low during reset at %0t", $time);
      end
    end else if (o_trace.valid === 1'b1) begin
      check_retire();
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d value mismatches, %0d other failures", value_errors,
               other_errors + 1);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int seed_val;
    i_rst          = 1'b1;
    i_bus_dv       = 1'b0;
    i_bus_rdata    = 32'h0;
    value_errors   = 0;
    other_errors   = 0;
    retired        = 0;
    cycles         = 0;
    seen_first_req = 1'b0;
    seed_val = $urandom(24915);
    build_program();
    run_model();
    repeat (4) @(posedge i_clk);
    #2;
    i_rst = 1'b0;
    while (o_halted !== 1'b1) begin
      @(negedge i_clk);
    end
    // Bus must stay quiet once halted
    repeat (HALT_QUIET) begin
      @(negedge i_clk);
      if (o_bus_req !== 1'b0) begin
        other_errors++;
        $display("Bus request after halt at %0t", $time);
      end
    end
    if (retired != ref_steps) begin
      report_value("halt_count", 32'(ref_steps), 32'(retired));
    end
    if (exp_st_addr.size() != 0) begin
      other_errors++;
      $display("%0d expected stores never reached the bus", exp_st_addr.size());
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_top.f
+incdir+tests
src/cpu_pkg.sv
src/alu.sv
src/bus_arbiter.sv
src/control_unit.sv
src/instruction_fetch.sv
src/load_store.sv
src/register_file.sv
src/cpu_top.sv
tests/tb_cpu_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

SOURCES := $(wildcard src/*.sv tests/*.sv tests/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
